// File: arcade_io_pkg.sv
//==============================
// Shared types and constants for the arcade board glue
// Scan codes are PS/2 set 2 make codes, extended prefix stripped
// Core input words in0/in1 are active low, in_a/in_b active high
// Struct fields are declared MSB first
//==============================

package arcade_io_pkg;

	// ==============================
	// Keyboard scan codes
	// ==============================
	localparam logic [7:0] key_up    = 8'h75;
	localparam logic [7:0] key_down  = 8'h72;
	localparam logic [7:0] key_left  = 8'h6b;
	localparam logic [7:0] key_right = 8'h74;
	localparam logic [7:0] key_w     = 8'h1d; // Player 2 up
	localparam logic [7:0] key_s     = 8'h1b;
	localparam logic [7:0] key_a     = 8'h1c;
	localparam logic [7:0] key_d     = 8'h23;
	localparam logic [7:0] key_esc   = 8'h76; // Coin
	localparam logic [7:0] key_f1    = 8'h05; // One player start
	localparam logic [7:0] key_f2    = 8'h06; // Two player start
	localparam logic [7:0] key_ctrl  = 8'h14;
	localparam logic [7:0] key_alt   = 8'h11;
	localparam logic [7:0] key_space = 8'h29;

	// Pixel clock enable divisor and counter width
	localparam int pix_div       = 4;
	localparam int pix_cnt_width = $clog2(pix_div);

	// Core sample width
	localparam int audio_width = 8;

	// ==============================
	// Control and video bundles
	// ==============================
	typedef struct packed {
		logic up;    // Bit 3, same order as the joystick word
		logic down;
		logic left;
		logic right;
	} player_ctrl_t;

	typedef struct packed {
		player_ctrl_t p1;
		player_ctrl_t p2;
		logic         coin;
		logic         start1;
		logic         start2;
		logic         fire1;
		logic         fire2;
		logic         fire3;
	} button_state_t;

	typedef struct packed {
		logic [3:0]   in0;  // Active low
		logic [7:0]   in1;  // Active low
		player_ctrl_t in_a;
		player_ctrl_t in_b;
	} core_inputs_t;

	typedef struct packed {
		logic [2:0] r;
		logic [2:0] g;
		logic [1:0] b;
	} rgb_core_t;

	typedef struct packed {
		logic [5:0] r;
		logic [5:0] g;
		logic [5:0] b;
		logic       hs;
		logic       vs;
	} vga_out_t;

	typedef struct packed {
		rgb_core_t rgb;
		logic      hs;
		logic      vs;
		logic      hblank;
		logic      vblank;
	} core_video_t;

endpackage

// File: key_decoder.sv
//==============================
// Keyboard strobe to held button levels
// One code per strobe, key_pressed gives the new level
// Unknown codes leave every button unchanged
// No debounce, no repeat handling
//==============================

`timescale 1ns/100ps

module key_decoder (
	input  logic                         clk_sys,
	input  logic                         reset,
	input  logic                         key_strobe,
	input  logic                         key_pressed,
	input  logic [7:0]                   key_code,
	output arcade_io_pkg::button_state_t buttons
);

	import arcade_io_pkg::*;

	// ==============================
	// Button latches
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			buttons <= '0; // All released
		end else if (key_strobe) begin
			case (key_code)
				// Player 1 arrows
				key_up: begin
					buttons.p1.up <= key_pressed;
				end
				key_down: begin
					buttons.p1.down <= key_pressed;
				end
				key_left: begin
					buttons.p1.left <= key_pressed;
				end
				key_right: begin
					buttons.p1.right <= key_pressed;
				end
				// Player 2 on WASD
				key_w: begin
					buttons.p2.up <= key_pressed;
				end
				key_s: begin
					buttons.p2.down <= key_pressed;
				end
				key_a: begin
					buttons.p2.left <= key_pressed;
				end
				key_d: begin
					buttons.p2.right <= key_pressed;
				end
				key_esc: begin
					buttons.coin <= key_pressed;
				end
				key_f1: begin
					buttons.start1 <= key_pressed;
				end
				key_f2: begin
					buttons.start2 <= key_pressed;
				end
				key_space: begin
					buttons.fire1 <= key_pressed;
				end
				key_alt: begin
					buttons.fire2 <= key_pressed;
				end
				key_ctrl: begin
					buttons.fire3 <= key_pressed;
				end
				default: begin
					// Not a game key
				end
			endcase
		end
	end

endmodule

// File: control_mapper.sv
//==============================
// Keys plus joysticks into core input words
// Joystick bits 3..0 are up, down, left, right
// rotate low turns controls for a vertical monitor
// Output is registered, one cycle behind its inputs
//==============================

`timescale 1ns/100ps

module control_mapper (
	input  logic                         clk_sys,
	input  logic                         reset,
	input  arcade_io_pkg::button_state_t buttons,
	input  logic [7:0]                   joystick_0,
	input  logic [7:0]                   joystick_1,
	input  logic                         rotate,
	output arcade_io_pkg::core_inputs_t  core_in
);

	import arcade_io_pkg::*;

	player_ctrl_t merged_1, merged_2;   // Key OR joystick
	player_ctrl_t mapped_1, mapped_2;   // After rotation
	core_inputs_t core_next;

	// Direction fields line up with joystick bits 3..0
	assign merged_1 = buttons.p1 | player_ctrl_t'(joystick_0[3:0]);
	assign merged_2 = buttons.p2 | player_ctrl_t'(joystick_1[3:0]);

	// ==============================
	// Rotation and packing
	// ==============================
	always_comb begin
		if (rotate) begin
			mapped_1 = merged_1;
			mapped_2 = merged_2;
		end else begin
			// Quarter turn of the stick
			mapped_1 = '{up: merged_1.left, down: merged_1.right,
				left: merged_1.down, right: merged_1.up};
			mapped_2 = '{up: merged_2.left, down: merged_2.right,
				left: merged_2.down, right: merged_2.up};
		end

		core_next.in0  = ~{2'b00, buttons.coin, 1'b0};
		core_next.in1  = ~{1'b0, buttons.start2, buttons.start1, 5'b00000};
		core_next.in_a = mapped_1;
		core_next.in_b = mapped_2;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			core_in.in0  <= '1;  // Nothing pressed, active low
			core_in.in1  <= '1;
			core_in.in_a <= '0;
			core_in.in_b <= '0;
		end else begin
			core_in <= core_next;
		end
	end

endmodule

// File: video_output.sv
//==============================
// Pixel enable, blanking and colour widening
// ce_pix is one cycle high every pix_div clocks
// Core colour is 3/3/2 bits, output is 6 bits per channel
// Core syncs are active high, outputs active low
// vga is registered on every clock, not on ce_pix
//==============================

`timescale 1ns/100ps

module video_output (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  arcade_io_pkg::core_video_t core_video,
	output logic                       ce_pix,
	output arcade_io_pkg::vga_out_t    vga
);

	import arcade_io_pkg::*;

	logic [pix_cnt_width-1:0] pix_cnt;
	logic                     blank;
	vga_out_t                 vga_next;

	// ==============================
	// Pixel clock enable
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pix_cnt <= '0;
			ce_pix  <= 1'b0;
		end else begin
			if (pix_cnt == pix_cnt_width'(pix_div - 1)) begin
				pix_cnt <= '0;
			end else begin
				pix_cnt <= pix_cnt + 1'b1;
			end
			// High on the edge that wraps the counter
			ce_pix <= (pix_cnt == pix_cnt_width'(pix_div - 1));
		end
	end

	// ==============================
	// Colour path
	// ==============================
	assign blank = core_video.hblank | core_video.vblank;

	always_comb begin
		if (blank) begin
			vga_next.r = '0;
			vga_next.g = '0;
			vga_next.b = '0;
		end else begin
			// Bit repeat keeps full white at 6'h3f
			vga_next.r = {core_video.rgb.r, core_video.rgb.r};
			vga_next.g = {core_video.rgb.g, core_video.rgb.g};
			vga_next.b = {core_video.rgb.b, core_video.rgb.b, core_video.rgb.b};
		end
		vga_next.hs = ~core_video.hs;  // Sync inverted even in blank
		vga_next.vs = ~core_video.vs;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			vga <= '0;
		end else begin
			vga <= vga_next;
		end
	end

endmodule

// File: audio_dac.sv
//==============================
// First order sigma-delta, one bit out
// sample is unsigned, zero is silence
// Over 2**width clocks the number of ones equals sample
// Needs an external RC low-pass on the pin
//==============================

`timescale 1ns/100ps

module audio_dac #(
	parameter int width = arcade_io_pkg::audio_width
) (
	input  logic             clk_sys,
	input  logic             reset,
	input  logic [width-1:0] sample,
	output logic             dac_out
);

	logic [width:0] acc;  // Extra bit holds the carry

	// Low bits carry the error forward
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			acc <= '0;
		end else begin
			acc <= {1'b0, acc[width-1:0]} + {1'b0, sample};
		end
	end

	assign dac_out = acc[width];  // Carry of the last add

endmodule

// File: arcade_io_top.sv
//==============================
// Board glue around the arcade game core
// Single clock domain, clk_sys drives everything
// Audio is mono, both channels carry the same stream
// No PLL, scandoubler or configuration channel here
//==============================

`timescale 1ns/100ps

module arcade_io_top (
	input  logic                                clk_sys,
	input  logic                                reset,

	// Keyboard
	input  logic                                key_strobe,
	input  logic                                key_pressed,
	input  logic [7:0]                          key_code,

	// Joysticks and control options
	input  logic [7:0]                          joystick_0,
	input  logic [7:0]                          joystick_1,
	input  logic                                rotate,

	// From the core
	input  arcade_io_pkg::core_video_t          core_video,
	input  logic [arcade_io_pkg::audio_width-1:0] core_audio,

	// To the core and the board
	output logic                                ce_pix,
	output arcade_io_pkg::core_inputs_t         core_in,
	output arcade_io_pkg::vga_out_t             vga,
	output logic                                audio_l,
	output logic                                audio_r
);

	import arcade_io_pkg::*;

	button_state_t buttons;

	// ==============================
	// Controls
	// ==============================
	key_decoder u_key_decoder (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.buttons     (buttons)
	);

	control_mapper u_control_mapper (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.buttons    (buttons),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.rotate     (rotate),
		.core_in    (core_in)
	);

	// ==============================
	// Video and audio
	// ==============================
	video_output u_video_output (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.core_video (core_video),
		.ce_pix     (ce_pix),
		.vga        (vga)
	);

	audio_dac #(
		.width (audio_width)
	) u_audio_dac (
		.clk_sys (clk_sys),
		.reset   (reset),
		.sample  (core_audio),
		.dac_out (audio_l)
	);

	assign audio_r = audio_l;  // Mono

endmodule

// File: tb_arcade_io.sv
//==============================
// Testbench for the arcade board glue
// Inputs change 1 ns after the rising edge
// A model updated on each rising edge is compared on the falling edge
// Audio runs reset the DUT with the sample already held
//==============================

`timescale 1ns/100ps

module tb_arcade_io;

	import arcade_io_pkg::*;

	localparam int clk_period   = 8;
	localparam int drive_delay  = 1;
	localparam int reset_cycles = 5;
	localparam int pix_cycles   = 12;
	localparam int n_keys       = 60;
	localparam int n_joy        = 80;
	localparam int n_video      = 100;
	localparam int n_audio      = 6;
	localparam int audio_cycles = 256;
	// A key event takes at most 6 cycles, each audio run adds its own reset
	localparam int test_cycles = reset_cycles + pix_cycles + n_keys * 6 + n_joy + n_video
		+ n_audio * (audio_cycles + reset_cycles + 2);
	localparam int watchdog_cycles = test_cycles * 2;

	logic                   clk_sys = 1'b0;
	logic                   reset;
	logic                   key_strobe;
	logic                   key_pressed;
	logic [7:0]             key_code;
	logic [7:0]             joystick_0;
	logic [7:0]             joystick_1;
	logic                   rotate;
	core_video_t            core_video;
	logic [audio_width-1:0] core_audio;
	logic                   ce_pix;
	core_inputs_t           core_in;
	vga_out_t               vga;
	logic                   audio_l;
	logic                   audio_r;

	// Reference state
	button_state_t model_buttons;
	core_inputs_t  model_core_in;
	vga_out_t      model_vga;
	logic          model_ce;
	int            edge_cnt;  // Edges since reset release

	logic          check_on = 1'b0;
	int            errors = 0;
	int            checks = 0;
	logic [7:0]    known_codes [14];

	arcade_io_top DUT (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.joystick_0  (joystick_0),
		.joystick_1  (joystick_1),
		.rotate      (rotate),
		.core_video  (core_video),
		.core_audio  (core_audio),
		.ce_pix      (ce_pix),
		.core_in     (core_in),
		.vga         (vga),
		.audio_l     (audio_l),
		.audio_r     (audio_r)
	);

	always #(clk_period / 2) clk_sys = ~clk_sys;

	// ==============================
	// Reference functions
	// ==============================
	function automatic button_state_t decode_key(input button_state_t cur, input logic strobe,
			input logic pressed, input logic [7:0] code);
		button_state_t nxt;
		nxt = cur;
		if (strobe) begin
			case (code)
				key_up:    nxt.p1.up    = pressed;
				key_down:  nxt.p1.down  = pressed;
				key_left:  nxt.p1.left  = pressed;
				key_right: nxt.p1.right = pressed;
				key_w:     nxt.p2.up    = pressed;
				key_s:     nxt.p2.down  = pressed;
				key_a:     nxt.p2.left  = pressed;
				key_d:     nxt.p2.right = pressed;
				key_esc:   nxt.coin     = pressed;
				key_f1:    nxt.start1   = pressed;
				key_f2:    nxt.start2   = pressed;
				key_space: nxt.fire1    = pressed;
				key_alt:   nxt.fire2    = pressed;
				key_ctrl:  nxt.fire3    = pressed;
				default:   nxt = cur;   // Unknown code
			endcase
		end
		return nxt;
	endfunction

	// A known code always sets some button when pressed
	function automatic logic is_known(input logic [7:0] code);
		return decode_key('0, 1'b1, 1'b1, code) != '0;
	endfunction

	function automatic player_ctrl_t rotate_player(input player_ctrl_t keys,
			input logic [3:0] stick, input logic rot);
		logic u, d, l, r;
		u = keys.up | stick[3];
		d = keys.down | stick[2];
		l = keys.left | stick[1];
		r = keys.right | stick[0];
		if (rot) begin
			return '{up: u, down: d, left: l, right: r};
		end
		return '{up: l, down: r, left: d, right: u};  // Vertical monitor
	endfunction

	function automatic core_inputs_t map_controls(input button_state_t b, input logic [7:0] j0,
			input logic [7:0] j1, input logic rot);
		core_inputs_t res;
		res.in0  = ~{2'b00, b.coin, 1'b0};
		res.in1  = ~{1'b0, b.start2, b.start1, 5'b00000};
		res.in_a = rotate_player(b.p1, j0[3:0], rot);
		res.in_b = rotate_player(b.p2, j1[3:0], rot);
		return res;
	endfunction

	function automatic vga_out_t widen_video(input core_video_t v);
		vga_out_t w;
		w.hs = ~v.hs;
		w.vs = ~v.vs;
		if (v.hblank || v.vblank) begin
			w.r = '0;
			w.g = '0;
			w.b = '0;
		end else begin
			w.r = {2{v.rgb.r}};
			w.g = {2{v.rgb.g}};
			w.b = {3{v.rgb.b}};
		end
		return w;
	endfunction

	// Ones after a number of adds from a cleared accumulator
	function automatic int expected_ones(input int sample, input int cycles);
		return (sample * cycles) >> audio_width;
	endfunction

	// ==============================
	// Checks and helpers
	// ==============================
	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic next_cycle();
		@(posedge clk_sys);
		#drive_delay;
	endtask

	task automatic strobe_key(input logic [7:0] code, input logic pressed);
		next_cycle();
		key_strobe  = 1'b1;
		key_code    = code;
		key_pressed = pressed;
		next_cycle();
		key_strobe  = 1'b0;
		key_code    = 8'($urandom());  // Must be ignored without a strobe
	endtask

	function automatic logic [7:0] pick_known();
		int idx;
		idx = $urandom_range(0, 13);
		return known_codes[4'(idx)];
	endfunction

	// Model follows the DUT registers edge by edge
	always @(posedge clk_sys) begin
		if (reset) begin
			model_buttons = '0;
			model_core_in = core_inputs_t'(20'hfff00);
			model_vga     = '0;
			model_ce      = 1'b0;
			edge_cnt      = 0;
		end else begin
			model_core_in = map_controls(model_buttons, joystick_0, joystick_1, rotate);
			model_buttons = decode_key(model_buttons, key_strobe, key_pressed, key_code);
			model_vga     = widen_video(core_video);
			edge_cnt      = edge_cnt + 1;
			model_ce      = (edge_cnt % pix_div == 0);  // Every fourth edge after release
		end
	end

	always @(negedge clk_sys) begin
		if (check_on) begin
			compare_value("core_in", 32'(core_in), 32'(model_core_in));
			compare_value("vga", 32'(vga), 32'(model_vga));
			compare_value("ce_pix", 32'(ce_pix), 32'(model_ce));
			compare_value("audio_r", 32'(audio_r), 32'(audio_l));
		end
	end

	// ==============================
	// Stimulus
	// ==============================
	initial begin
		int kind;
		int s;
		int ones;
		logic [7:0] code;

		void'($urandom(32'hab8d));
		known_codes = '{key_up, key_down, key_left, key_right, key_w, key_s, key_a,
			key_d, key_esc, key_f1, key_f2, key_ctrl, key_alt, key_space};
		reset       = 1'b1;
		key_strobe  = 1'b0;
		key_pressed = 1'b0;
		key_code    = 8'h00;
		joystick_0  = 8'h00;
		joystick_1  = 8'h00;
		rotate      = 1'b0;
		core_video  = '0;
		core_audio  = '0;

		repeat (reset_cycles) @(posedge clk_sys);
		#drive_delay;
		reset    = 1'b0;
		check_on = 1'b1;
		compare_value("core_in", 32'(core_in), 32'h000fff00);  // Released value
		compare_value("vga", 32'(vga), 32'h0);
		compare_value("audio_l", 32'(audio_l), 32'h0);
		for (int k = 1; k <= pix_cycles; k++) begin
			next_cycle();
			compare_value("ce_pix", 32'(ce_pix), 32'(k % pix_div == 0));
		end

		// Key decoding
		for (int i = 0; i < n_keys; i++) begin
			kind = $urandom_range(0, 4);
			case (kind)
				0: strobe_key(pick_known(), 1'b1);
				1: strobe_key(pick_known(), 1'b0);
				2: begin
					code = pick_known();
					strobe_key(code, 1'b1);
					strobe_key(code, 1'b0);
				end
				3: begin
					code = 8'($urandom());
					while (is_known(code)) begin
						code = 8'($urandom());
					end
					strobe_key(code, 1'($urandom_range(0, 1)));
				end
				default: begin
					next_cycle();
					key_code    = pick_known();  // No strobe
					key_pressed = 1'b1;
				end
			endcase
			repeat ($urandom_range(0, 2)) next_cycle();
		end

		// Joysticks and rotation, keys still changing
		for (int i = 0; i < n_joy; i++) begin
			next_cycle();
			joystick_0 = 8'($urandom());
			joystick_1 = 8'($urandom());
			rotate     = 1'((i / 8) % 2);
			key_strobe = ($urandom_range(0, 3) == 0);
			key_code   = pick_known();
			key_pressed = 1'($urandom_range(0, 1));
		end
		next_cycle();
		key_strobe = 1'b0;

		// Video with random blanking
		for (int i = 0; i < n_video; i++) begin
			next_cycle();
			core_video = core_video_t'(12'($urandom()));
		end

		// Audio, sample held through reset
		for (int i = 0; i < n_audio; i++) begin
			s = (i == 0) ? 0 : (i == 1) ? 255 : $urandom_range(1, 254);
			next_cycle();
			reset      = 1'b1;
			core_audio = 8'(s);
			repeat (2) next_cycle();
			reset = 1'b0;
			ones  = 0;
			repeat (audio_cycles) begin
				next_cycle();
				if (audio_l === 1'b1) begin
					ones++;
				end
			end
			compare_value("audio_l ones", 32'(ones), 32'(expected_ones(s, audio_cycles)));
		end

		next_cycle();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(watchdog_cycles * clk_period);
		$display("Error: stimulus did not finish within %0d cycles", watchdog_cycles);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// File: arcade_io.f
arcade_io_pkg.sv
key_decoder.sv
control_mapper.sv
video_output.sv
audio_dac.sv
arcade_io_top.sv
tb_arcade_io.sv

// File: Makefile
# Verilator build for the arcade board glue
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
FILELIST  ?= arcade_io.f
TB_TOP    ?= tb_arcade_io
RTL_TOP   ?= arcade_io_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
